//--- hw/ipv4_pkg.sv
package ipv4_pkg;

	// One beat of the layer-2 or layer-3 receive stream
	typedef struct packed {
		// First beat of a frame
		logic		start;
		logic		data_valid;
		// Valid bytes counted from the top of data
		logic [4:0]	bytes_valid;
		// Frame end, keep it
		logic		commit;
		// Frame end, discard it
		logic		drop;
		// First byte of the beat in bits 127:120
		logic [127:0]	data;
	} eth_rx_bus_t;

	// First 16 bytes of an IPv4 header, wire order
	typedef struct packed {
		logic [3:0]	version;
		logic [3:0]	ihl;
		logic [7:0]	dscp_ecn;
		logic [15:0]	total_len;
		logic [15:0]	ident;
		logic		reserved;
		logic		df;
		logic		mf;
		logic [12:0]	frag_offset;
		logic [7:0]	ttl;
		logic [7:0]	protocol;
		logic [15:0]	hdr_csum;
		logic [31:0]	src_ip;
	} ipv4_hdr_word0_t;

	// Raw view for the checksum, field view for the header checks
	typedef union packed {
		logic [127:0]		raw;
		ipv4_hdr_word0_t	fields;
	} ipv4_hdr_word0_u;

	// Layer-3 header fields passed upward with each frame
	typedef struct packed {
		// Total length minus the fixed header
		logic [15:0]	payload_len;
		logic [7:0]	protocol;
		logic [31:0]	src_ip;
		logic [31:0]	dst_ip;
	} ipv4_l3_hdr_t;

	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
	// No options supported
	localparam logic [15:0] IPV4_HDR_BYTES = 16'd20;
	localparam logic [31:0] IPV4_BROADCAST = 32'hffff_ffff;

	// Wishbone word addresses
	localparam logic [1:0] REG_LOCAL_IP     = 2'd0;
	localparam logic [1:0] REG_COMMIT_COUNT = 2'd1;
	localparam logic [1:0] REG_DROP_COUNT   = 2'd2;

endpackage

//--- hw/ipv4_payload_aligner.sv
`timescale 1ns/100ps

module ipv4_payload_aligner import ipv4_pkg::*; (
	input  logic		rx_clk,
	input  logic		rst_n,
	input  eth_rx_bus_t	rx_bus,
	output logic [127:0]	aligned_data,
	output logic [4:0]	avail_bytes,
	output logic		frame_end
);

	// Newer copy
	eth_rx_bus_t	bus_ff;
	// Older copy
	eth_rx_bus_t	bus_ff2;
	// Older copy minus its four leading bytes
	logic [4:0]	older_bytes;

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			bus_ff  <= '0;
			bus_ff2 <= '0;
		end else begin
			bus_ff  <= rx_bus;
			bus_ff2 <= bus_ff;
		end
	end

	// A short tail word has already been merged one cycle earlier
	assign older_bytes = (bus_ff2.bytes_valid > 5'd4) ? (bus_ff2.bytes_valid - 5'd4) : 5'd0;

	always_comb begin
		if (bus_ff2.commit) begin
			// Older copy is the last word
			aligned_data = {bus_ff2.data[95:0], 32'h0};
			avail_bytes  = older_bytes;
			frame_end    = 1'b1;
		end else if (bus_ff.commit && (bus_ff.bytes_valid <= 5'd4)) begin
			// Short tail fits behind the older copy
			aligned_data = {bus_ff2.data[95:0], bus_ff.data[127:96]};
			avail_bytes  = older_bytes + bus_ff.bytes_valid;
			frame_end    = 1'b1;
		end else begin
			// Mid frame, full word
			aligned_data = {bus_ff2.data[95:0], bus_ff.data[127:96]};
			avail_bytes  = 5'd16;
			frame_end    = 1'b0;
		end
	end

	assert property (@(posedge rx_clk) disable iff (!rst_n)
		avail_bytes <= 5'd16);

endmodule

//--- hw/ipv4_hdr_checksum.sv
`timescale 1ns/100ps

module ipv4_hdr_checksum import ipv4_pkg::*; (
	input  logic		rx_clk,
	input  logic		rst_n,
	input  eth_rx_bus_t	rx_bus,
	output logic		csum_ok
);

	ipv4_hdr_word0_u	hdr;
	logic			st1_valid;
	logic			st2_valid;
	// Four 16-bit slices each, room for the carries
	logic [17:0]		sum_hi;
	logic [17:0]		sum_lo;
	logic [19:0]		sum_all;
	logic [16:0]		fold;
	logic [15:0]		fold_final;

	assign hdr = ipv4_hdr_word0_u'(rx_bus.data);

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			st1_valid <= 1'b0;
			st2_valid <= 1'b0;
		end else begin
			st1_valid <= rx_bus.start && rx_bus.data_valid;
			st2_valid <= st1_valid;
		end
	end

	always_ff @(posedge rx_clk) begin
		// Stage 1, whole first header word
		if (rx_bus.start && rx_bus.data_valid) begin
			sum_hi <= 18'(hdr.raw[127:112]) + 18'(hdr.raw[111:96]) +
				18'(hdr.raw[95:80]) + 18'(hdr.raw[79:64]);
			sum_lo <= 18'(hdr.raw[63:48]) + 18'(hdr.raw[47:32]) +
				18'(hdr.raw[31:16]) + 18'(hdr.raw[15:0]);
		end
		// Stage 2, destination address from the next word
		if (st1_valid) begin
			sum_all <= 20'(sum_hi) + 20'(sum_lo) +
				20'(rx_bus.data[127:112]) + 20'(rx_bus.data[111:96]);
		end
		// Stage 3, first end-around carry
		if (st2_valid) begin
			fold <= 17'(sum_all[15:0]) + 17'(sum_all[19:16]);
		end
	end

	// Second carry can no longer overflow
	assign fold_final = fold[15:0] + 16'(fold[16]);

	// Held until the next start word reaches stage 3
	assign csum_ok = (fold_final == 16'hffff);

endmodule

//--- hw/ipv4_rx_len_counter.sv
`timescale 1ns/100ps

module ipv4_rx_len_counter (
	input  logic		rx_clk,
	input  logic		rst_n,
	input  logic		len_load,
	input  logic [15:0]	load_len,
	input  logic		len_step,
	input  logic [4:0]	avail_bytes,
	input  logic		frame_end,
	output logic [4:0]	take_bytes,
	output logic		len_last
);

	// Payload bytes still owed to the upper layer
	logic [15:0]	remaining;
	logic		fits;

	assign fits = remaining <= 16'(avail_bytes);

	// Trim to the IPv4 length, padding falls off here
	assign take_bytes = fits ? remaining[4:0] : avail_bytes;
	assign len_last   = fits || frame_end;

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			remaining <= '0;
		end else if (len_load) begin
			remaining <= load_len;
		end else if (len_step) begin
			remaining <= remaining - 16'(take_bytes);
		end
	end

	// Last beat is the final step until the next load
	assert property (@(posedge rx_clk) disable iff (!rst_n)
		(len_step && len_last) |=> !len_step);

endmodule

//--- hw/ipv4_rx_fsm.sv
`timescale 1ns/100ps

module ipv4_rx_fsm import ipv4_pkg::*; (
	input  logic		rx_clk,
	input  logic		rst_n,
	input  eth_rx_bus_t	rx_bus,
	input  logic [15:0]	rx_ethertype,
	input  logic [31:0]	local_ip,
	input  logic [127:0]	aligned_data,
	input  logic [4:0]	avail_bytes,
	input  logic		frame_end,
	input  logic		csum_ok,
	input  logic [4:0]	take_bytes,
	input  logic		len_last,
	output logic		len_load,
	output logic		len_step,
	output logic [15:0]	load_len,
	output logic		frame_commit,
	output logic		frame_drop,
	output eth_rx_bus_t	rx_l3_bus,
	output ipv4_l3_hdr_t	rx_l3_headers
);

	typedef enum logic [2:0] {IDLE, SECOND, THIRD, BODY_FIRST, BODY, SKIP} state_t;

	state_t			state;
	ipv4_hdr_word0_u	hdr;
	logic			hdr_ok;
	logic			dst_ok;
	logic			abort;
	// Input commit already seen for the current frame
	logic			in_end;

	// Start word viewed as header fields
	assign hdr = ipv4_hdr_word0_u'(rx_bus.data);

	// Plain 20 byte header, unfragmented, full first word
	assign hdr_ok = rx_bus.start && rx_bus.data_valid && (rx_bus.bytes_valid == 5'd16) &&
		(rx_ethertype == ETHERTYPE_IPV4) &&
		(hdr.fields.version == 4'd4) && (hdr.fields.ihl == 4'd5) &&
		(hdr.fields.total_len >= IPV4_HDR_BYTES) &&
		!hdr.fields.reserved && !hdr.fields.mf && (hdr.fields.frag_offset == 13'd0);

	// Destination sits in the top four bytes of word 1
	assign dst_ok = rx_bus.data_valid && (rx_bus.bytes_valid >= 5'd4) &&
		((rx_bus.data[127:96] == local_ip) || (rx_bus.data[127:96] == IPV4_BROADCAST));

	// Upstream drop only matters once the frame is ours
	assign abort = rx_bus.drop &&
		((state == SECOND) ? dst_ok : (state inside {THIRD, BODY_FIRST, BODY}));

	assign len_load = (state == SECOND) && dst_ok;
	assign load_len = rx_l3_headers.payload_len;
	assign len_step = (state == BODY_FIRST) || (state == BODY);

	// Exactly one end beat per frame
	assign frame_commit = rx_l3_bus.commit;
	assign frame_drop   = rx_l3_bus.drop;

	// Header fields, held until the next accepted frame
	always_ff @(posedge rx_clk) begin
		if ((state == IDLE) && hdr_ok) begin
			rx_l3_headers.payload_len <= hdr.fields.total_len - IPV4_HDR_BYTES;
			rx_l3_headers.protocol    <= hdr.fields.protocol;
			rx_l3_headers.src_ip      <= hdr.fields.src_ip;
		end
		if (len_load) begin
			rx_l3_headers.dst_ip <= rx_bus.data[127:96];
		end
	end

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			in_end    <= 1'b0;
			rx_l3_bus <= '0;
		end else begin
			// Output beats are single cycle
			rx_l3_bus <= '0;
			if (rx_bus.commit) begin
				in_end <= 1'b1;
			end
			case (state)
				IDLE: begin
					in_end <= 1'b0;
					if (hdr_ok) begin
						state <= SECOND;
					end
				end
				// Wrong destination is discarded silently
				SECOND: state <= dst_ok ? THIRD : IDLE;
				// Aligner and checksum catching up
				THIRD: state <= BODY_FIRST;
				BODY_FIRST, BODY: begin
					rx_l3_bus.start       <= (state == BODY_FIRST);
					// Nothing left in the aligner means an end-only beat
					rx_l3_bus.data_valid  <= (avail_bytes != 5'd0);
					rx_l3_bus.bytes_valid <= take_bytes;
					rx_l3_bus.data        <= aligned_data;
					state                 <= BODY;
					if (len_last) begin
						rx_l3_bus.commit <= csum_ok;
						rx_l3_bus.drop   <= !csum_ok;
						// Padding still coming unless the input already ended
						state <= (frame_end || in_end || rx_bus.commit) ? IDLE : SKIP;
					end
				end
				// Swallow padding
				SKIP: begin
					if (rx_bus.commit || rx_bus.drop) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
			// Upstream abort gets a beat of its own
			if (abort) begin
				rx_l3_bus      <= '0;
				rx_l3_bus.drop <= 1'b1;
				state          <= IDLE;
			end
		end
	end

	// First output word trails the accepted start word by four edges
	assert property (@(posedge rx_clk) disable iff (!rst_n)
		rx_l3_bus.start |-> $past(rx_bus.start, 4));

endmodule

//--- hw/ipv4_cfg_regs.sv
`timescale 1ns/100ps

module ipv4_cfg_regs import ipv4_pkg::*; #(
	parameter int STAT_WIDTH = 32
) (
	input  logic		rx_clk,
	input  logic		rst_n,
	input  logic		wb_cyc,
	input  logic		wb_stb,
	input  logic		wb_we,
	input  logic [1:0]	wb_adr,
	input  logic [31:0]	wb_dat_w,
	output logic [31:0]	wb_dat_r,
	output logic		wb_ack,
	input  logic		frame_commit,
	input  logic		frame_drop,
	output logic [31:0]	local_ip
);

	logic [STAT_WIDTH-1:0]	commit_count;
	logic [STAT_WIDTH-1:0]	drop_count;
	// New access this cycle
	logic			wb_req;

	assign wb_req = wb_cyc && wb_stb && !wb_ack;

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack       <= 1'b0;
			local_ip     <= '0;
			commit_count <= '0;
			drop_count   <= '0;
		end else begin
			wb_ack <= wb_req;
			// Only the address register is writable
			if (wb_req && wb_we && (wb_adr == REG_LOCAL_IP)) begin
				local_ip <= wb_dat_w;
			end
			// Counters wrap
			if (frame_commit) begin
				commit_count <= commit_count + 1'b1;
			end
			if (frame_drop) begin
				drop_count <= drop_count + 1'b1;
			end
		end
	end

	// Read data lands with the ack
	always_ff @(posedge rx_clk) begin
		if (wb_req) begin
			case (wb_adr)
				REG_LOCAL_IP:     wb_dat_r <= local_ip;
				REG_COMMIT_COUNT: wb_dat_r <= 32'(commit_count);
				REG_DROP_COUNT:   wb_dat_r <= 32'(drop_count);
				default:          wb_dat_r <= '0;
			endcase
		end
	end

	// A frame end counts as commit or drop, never both
	assert property (@(posedge rx_clk) disable iff (!rst_n)
		!(frame_commit && frame_drop));

endmodule

//--- hw/ipv4_rx_top.sv
`timescale 1ns/100ps

module ipv4_rx_top import ipv4_pkg::*; #(
	parameter int STAT_WIDTH = 32
) (
	input  logic		rx_clk,
	input  logic		rst_n,
	input  eth_rx_bus_t	rx_bus,
	input  logic [15:0]	rx_ethertype,
	input  logic		wb_cyc,
	input  logic		wb_stb,
	input  logic		wb_we,
	input  logic [1:0]	wb_adr,
	input  logic [31:0]	wb_dat_w,
	output logic [31:0]	wb_dat_r,
	output logic		wb_ack,
	output eth_rx_bus_t	rx_l3_bus,
	output ipv4_l3_hdr_t	rx_l3_headers
);

	// Aligner to FSM and counter
	logic [127:0]	aligned_data;
	logic [4:0]	avail_bytes;
	logic		frame_end;
	// Length counter handshake
	logic		len_load;
	logic		len_step;
	logic [15:0]	load_len;
	logic [4:0]	take_bytes;
	logic		len_last;
	logic		csum_ok;
	// Statistics and configuration
	logic		frame_commit;
	logic		frame_drop;
	logic [31:0]	local_ip;

	ipv4_payload_aligner ipv4_payload_aligner_inst (.*);

	ipv4_hdr_checksum ipv4_hdr_checksum_inst (.*);

	ipv4_rx_len_counter ipv4_rx_len_counter_inst (.*);

	ipv4_rx_fsm ipv4_rx_fsm_inst (.*);

	ipv4_cfg_regs #(
		.STAT_WIDTH(STAT_WIDTH)
	) ipv4_cfg_regs_inst (.*);

endmodule

//--- dv/ipv4_rx_tb.sv
`timescale 1ns/100ps

module ipv4_rx_tb import ipv4_pkg::*; ();

	// 40 frames of up to 12 words, twice over, plus setup
	localparam int TIMEOUT_CYCLES = 40 * 12 * 2 + 200;
	localparam logic [31:0] LFSR_SEED = 32'h8c4b_b506;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [31:0] LOCAL_IP = 32'hc0a8_010a;
	localparam logic [31:0] SRC_IP = 32'hc0a8_0164;
	localparam logic [31:0] OTHER_IP = 32'hc0a8_010b;

	logic		rx_clk;
	logic		rst_n;
	eth_rx_bus_t	rx_bus;
	logic [15:0]	rx_ethertype;
	logic		wb_cyc;
	logic		wb_stb;
	logic		wb_we;
	logic [1:0]	wb_adr;
	logic [31:0]	wb_dat_w;
	logic [31:0]	wb_dat_r;
	logic		wb_ack;
	eth_rx_bus_t	rx_l3_bus;
	ipv4_l3_hdr_t	rx_l3_headers;

	int		errors = 0;
	int		checks = 0;
	int		cycles = 0;
	// Cycle number of the edge that samples the start word
	int		start_cycle = 0;
	int		out_beats = 0;
	int		exp_commits = 0;
	int		exp_drops = 0;
	logic [31:0]	lfsr = LFSR_SEED;
	logic [7:0]	tx_payload[$];
	logic [7:0]	rx_payload[$];
	// Header variations for the next frame
	logic [15:0]	knob_ethertype;
	logic [3:0]	knob_ihl;
	logic		knob_mf;
	logic [12:0]	knob_frag;
	logic		knob_rsv;
	logic		knob_bad_csum;
	// Word index replaced by an upstream drop, negative for none
	int		knob_drop_word;

	ipv4_rx_top #(
		.STAT_WIDTH(32)
	) ipv4_rx_top_inst (.*);

	initial begin
		rx_clk = 1'b0;
		forever #4 rx_clk = ~rx_clk;
	end

	always @(posedge rx_clk) begin
		cycles <= cycles + 1;
		// Any beat that carries data or an end
		if (rx_l3_bus.data_valid || rx_l3_bus.commit || rx_l3_bus.drop) begin
			out_beats <= out_beats + 1;
		end
	end

	task automatic check_value(input string name, input logic [136:0] got,
			input logic [136:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// Galois form, shift right
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic random_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// RFC 1071 sum over the ten header halfwords
	function automatic logic [15:0] header_checksum(input logic [159:0] hdr);
		logic [31:0] sum;
		sum = '0;
		for (int i = 0; i < 10; i++) begin
			sum = sum + 32'(hdr[159 - 16 * i -: 16]);
		end
		while (sum[31:16] != 16'h0) begin
			sum = 32'(sum[15:0]) + 32'(sum[31:16]);
		end
		return ~sum[15:0];
	endfunction

	task automatic reset_knobs();
		knob_ethertype = ETHERTYPE_IPV4;
		knob_ihl = 4'd5;
		knob_mf = 1'b0;
		knob_frag = '0;
		knob_rsv = 1'b0;
		knob_bad_csum = 1'b0;
		knob_drop_word = -1;
	endtask

	task automatic send_frame(input int pay_len, input int pad_len, input logic [31:0] dst);
		ipv4_hdr_word0_t	h;
		logic [159:0]		hdr_bits;
		logic [7:0]		frame[$];
		logic [7:0]		b;
		eth_rx_bus_t		word;
		int			nwords;
		int			idx;
		h = '0;
		h.version = 4'd4;
		h.ihl = knob_ihl;
		h.total_len = 16'(20 + pay_len);
		h.ident = 16'(cycles);
		h.reserved = knob_rsv;
		h.mf = knob_mf;
		h.frag_offset = knob_frag;
		h.ttl = 8'd64;
		h.protocol = 8'd17;
		h.src_ip = SRC_IP;
		h.hdr_csum = header_checksum({h, dst});
		if (knob_bad_csum) begin
			h.hdr_csum = h.hdr_csum ^ 16'h0100;
		end
		hdr_bits = {h, dst};
		tx_payload.delete();
		for (int i = 0; i < 20; i++) begin
			frame.push_back(hdr_bits[159 - 8 * i -: 8]);
		end
		for (int i = 0; i < pay_len + pad_len; i++) begin
			random_byte(b);
			frame.push_back(b);
			// Padding is not payload
			if (i < pay_len) begin
				tx_payload.push_back(b);
			end
		end
		nwords = (frame.size() + 15) / 16;
		for (int w = 0; w < nwords; w++) begin
			word = '0;
			if (w == knob_drop_word) begin
				word.drop = 1'b1;
			end else begin
				word.start = (w == 0);
				word.data_valid = 1'b1;
				word.commit = (w == nwords - 1);
				for (int k = 0; k < 16; k++) begin
					idx = 16 * w + k;
					if (idx < frame.size()) begin
						word.data[127 - 8 * k -: 8] = frame[idx];
						word.bytes_valid = word.bytes_valid + 5'd1;
					end
				end
			end
			@(negedge rx_clk);
			rx_bus = word;
			rx_ethertype = knob_ethertype;
			if (w == 0) begin
				start_cycle = cycles + 1;
			end
			if (word.drop) begin
				break;
			end
		end
		@(negedge rx_clk);
		rx_bus = '0;
		rx_ethertype = ETHERTYPE_IPV4;
	endtask

	// Gathers output bytes until the frame ends
	task automatic collect_frame(output logic got_commit, output logic got_drop);
		int beats;
		beats = 0;
		got_commit = 1'b0;
		got_drop = 1'b0;
		rx_payload.delete();
		while (!got_commit && !got_drop) begin
			@(negedge rx_clk);
			if (rx_l3_bus.data_valid || rx_l3_bus.commit || rx_l3_bus.drop) begin
				check_value("rx_l3_bus.start", rx_l3_bus.start, beats == 0);
				if (beats == 0) begin
					check_value("first beat latency", cycles - start_cycle, 3);
				end
				// Upstream drop is an end-only beat right behind the edge that saw it
				if (rx_l3_bus.drop && knob_drop_word >= 0) begin
					check_value("rx_l3_bus.data_valid", rx_l3_bus.data_valid, 1'b0);
					check_value("drop beat latency", cycles - start_cycle, knob_drop_word);
				end
				if (rx_l3_bus.data_valid) begin
					for (int i = 0; i < rx_l3_bus.bytes_valid; i++) begin
						rx_payload.push_back(rx_l3_bus.data[127 - 8 * i -: 8]);
					end
				end
				got_commit = rx_l3_bus.commit;
				got_drop = rx_l3_bus.drop;
				beats++;
			end
		end
	endtask

	task automatic run_frame(input int pay_len, input int pad_len, input logic [31:0] dst,
			input logic exp_drop);
		logic got_commit;
		logic got_drop;
		fork
			send_frame(pay_len, pad_len, dst);
			collect_frame(got_commit, got_drop);
		join
		check_value("rx_l3_bus.commit", got_commit, !exp_drop);
		check_value("rx_l3_bus.drop", got_drop, exp_drop);
		// Full payload and headers unless cut short upstream
		if (knob_drop_word < 0) begin
			check_value("payload length", rx_payload.size(), tx_payload.size());
			for (int i = 0; i < rx_payload.size() && i < tx_payload.size(); i++) begin
				check_value("payload byte", rx_payload[i], tx_payload[i]);
			end
			check_value("rx_l3_headers.payload_len", rx_l3_headers.payload_len, pay_len);
			check_value("rx_l3_headers.protocol", rx_l3_headers.protocol, 8'd17);
			check_value("rx_l3_headers.src_ip", rx_l3_headers.src_ip, SRC_IP);
			check_value("rx_l3_headers.dst_ip", rx_l3_headers.dst_ip, dst);
		end
		if (exp_drop) begin
			exp_drops++;
		end else begin
			exp_commits++;
		end
		repeat (4) @(negedge rx_clk);
	endtask

	task automatic reject_frame(input string what, input logic [31:0] dst);
		int beats_before;
		beats_before = out_beats;
		send_frame(12, 0, dst);
		repeat (8) @(negedge rx_clk);
		checks++;
		if (out_beats != beats_before) begin
			errors++;
			$display("A frame with %s was passed upward instead of being discarded", what);
		end
		reset_knobs();
	endtask

	// Master holds the request until the ack
	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int waits;
		waits = 0;
		@(negedge rx_clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		do begin
			@(negedge rx_clk);
			waits++;
		end while (!wb_ack && waits < 8);
		if (!wb_ack) begin
			errors++;
			$display("Wishbone access to address %0d was never acknowledged", adr);
		end
		check_value("wb_ack latency", waits, 1);
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read_check(input logic [1:0] adr, input logic [31:0] exp,
			input string name);
		logic [31:0] rdata;
		wb_access(1'b0, adr, 32'h0, rdata);
		check_value(name, rdata, exp);
	endtask

	task automatic test_reset_state();
		check_value("rx_l3_bus", rx_l3_bus, '0);
		wb_read_check(REG_LOCAL_IP, 32'h0, "local_ip");
		wb_read_check(REG_COMMIT_COUNT, 32'h0, "commit_count");
		wb_read_check(REG_DROP_COUNT, 32'h0, "drop_count");
	endtask

	task automatic test_local_ip();
		logic [31:0] unused;
		wb_access(1'b1, REG_LOCAL_IP, LOCAL_IP, unused);
		wb_read_check(REG_LOCAL_IP, LOCAL_IP, "local_ip");
		// Counter write ignored, unused address reads zero
		wb_access(1'b1, REG_COMMIT_COUNT, 32'h55, unused);
		wb_read_check(REG_COMMIT_COUNT, 32'h0, "commit_count");
		wb_read_check(2'd3, 32'h0, "unused register");
	endtask

	task automatic test_valid_frames();
		int sizes[7];
		sizes = '{1, 4, 5, 12, 16, 28, 60};
		for (int i = 0; i < 7; i++) begin
			run_frame(sizes[i], 0, (i % 2 == 0) ? LOCAL_IP : IPV4_BROADCAST, 1'b0);
		end
	endtask

	task automatic test_padding();
		// Minimum Ethernet payload, three full words, and a long tail through SKIP
		run_frame(5, 21, LOCAL_IP, 1'b0);
		run_frame(16, 12, IPV4_BROADCAST, 1'b0);
		run_frame(1, 59, LOCAL_IP, 1'b0);
	endtask

	task automatic test_rejected_frames();
		knob_ethertype = 16'h86dd;
		reject_frame("an IPv6 ethertype", LOCAL_IP);
		knob_ihl = 4'd6;
		reject_frame("IHL 6", LOCAL_IP);
		knob_mf = 1'b1;
		reject_frame("MF set", LOCAL_IP);
		knob_frag = 13'd185;
		reject_frame("a nonzero fragment offset", LOCAL_IP);
		knob_rsv = 1'b1;
		reject_frame("the reserved flag set", LOCAL_IP);
		reject_frame("a foreign destination", OTHER_IP);
	endtask

	task automatic test_drops_and_counters();
		knob_bad_csum = 1'b1;
		run_frame(28, 0, LOCAL_IP, 1'b1);
		reset_knobs();
		// Abort after the first output word
		knob_drop_word = 4;
		run_frame(60, 0, LOCAL_IP, 1'b1);
		reset_knobs();
		wb_read_check(REG_COMMIT_COUNT, 32'(exp_commits), "commit_count");
		wb_read_check(REG_DROP_COUNT, 32'(exp_drops), "drop_count");
	endtask

	initial begin : watchdog
		while (cycles < TIMEOUT_CYCLES) begin
			@(negedge rx_clk);
		end
		$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		rx_bus = '0;
		rx_ethertype = ETHERTYPE_IPV4;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		reset_knobs();
		repeat (10) @(posedge rx_clk);
		@(negedge rx_clk);
		rst_n = 1'b1;
		test_reset_state();
		test_local_ip();
		test_valid_frames();
		test_padding();
		test_rejected_frames();
		test_drops_and_counters();
		repeat (4) @(negedge rx_clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- flist.f
hw/ipv4_pkg.sv
hw/ipv4_payload_aligner.sv
hw/ipv4_hdr_checksum.sv
hw/ipv4_rx_len_counter.sv
hw/ipv4_rx_fsm.sv
hw/ipv4_cfg_regs.sv
hw/ipv4_rx_top.sv
dv/ipv4_rx_tb.sv

//--- Makefile
SIM_DIR ?= sim_build
TOP ?= ipv4_rx_tb
FLIST ?= flist.f
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
LOG ?= $(SIM_DIR)/sim.log

PASS_MSG := Simulation completed successfully
SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(SIM_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(SIM_DIR)
